// ==== executeStage.f ====
+incdir+include
design/datapathPkg.sv
design/isaPkg.sv
design/instrDecoder.sv
design/aluUnit.sv
design/memAccessUnit.sv
design/flagRegister.sv
design/branchCondition.sv
design/executeStage.sv
bench/executeStageTb.sv

// ==== include/executeVectors.svh ====
`ifndef EXECUTE_VECTORS_SVH
`define EXECUTE_VECTORS_SVH

// One row per cycle with stimulus, expected outputs and NZCV after the edge
typedef struct packed {
    instr_t     instr;
    regRead_t   expRd;
    regData_t   regData;
    writeBack_t expWb;
    memReq_t    expMem;
    logic       expTaken;
    flags_t     expFlags;
} vecRow_t;

localparam regRead_t   noReads = '0;
localparam writeBack_t noWb    = '0;
localparam memReq_t    noMem   = '0;

vecRow_t vectors[$];

function automatic instr_t aluInstr(logic immForm, aluFunc_t fn, regIdx_t d, regIdx_t s1,
                                    regIdx_t s2, imm_t imm);
    instr_t i;
    i = '0;
    i.valid   = 1'b1;
    i.opClass = immForm ? immOp : regOp;
    i.special = immForm;   // ALU op inside the immediate class
    i.aluFunc = fn;
    i.dest    = d;
    i.src1    = s1;
    i.src2    = s2;
    i.imm     = imm;
    return i;
endfunction

function automatic instr_t moveInstr(moveFunc_t fn, regIdx_t d, regIdx_t s1, imm_t imm);
    instr_t i;
    i = '0;
    i.valid    = 1'b1;
    i.opClass  = immOp;
    i.moveFunc = fn;
    i.dest     = d;
    i.src1     = s1;
    i.imm      = imm;
    return i;
endfunction

function automatic instr_t memInstr(logic store, regIdx_t d, regIdx_t base, imm_t offset);
    instr_t i;
    i = '0;
    i.valid    = 1'b1;
    i.opClass  = memOp;
    i.moveFunc = store ? mvMovt : mvMov;   // Bit 0 picks store
    i.dest     = d;
    i.src1     = base;
    i.imm      = offset;
    return i;
endfunction

function automatic instr_t branchInstr(branchCond_t c);
    instr_t i;
    i = '0;
    i.valid   = 1'b1;
    i.opClass = branchOp;
    i.cond    = c;
    return i;
endfunction

function automatic instr_t markIdle(instr_t i);
    instr_t r;
    r = i;
    r.valid = 1'b0;
    return r;
endfunction

function automatic regRead_t readsOf(regIdx_t d, regIdx_t f, regIdx_t s);
    regRead_t r;
    r.dest   = d;
    r.first  = f;
    r.second = s;
    return r;
endfunction

function automatic writeBack_t wbTo(regIdx_t addr, word_t data);
    writeBack_t wb;
    wb.we   = 1'b1;
    wb.addr = addr;
    wb.data = data;
    return wb;
endfunction

function automatic memReq_t memOf(logic rd, logic wr, word_t addr, word_t data);
    memReq_t m;
    m.read  = rd;
    m.write = wr;
    m.addr  = addr;
    m.data  = data;
    return m;
endfunction

task automatic addRow(instr_t i, regRead_t rd, word_t dOld, word_t a, word_t b,
                      writeBack_t wb, memReq_t mem, logic taken, logic [3:0] nzcv);
    vecRow_t row;
    row.instr    = i;
    row.expRd    = rd;
    row.regData  = '{dest: dOld, first: a, second: b};
    row.expWb    = wb;
    row.expMem   = mem;
    row.expTaken = taken;
    row.expFlags = flags_t'(nzcv);
    vectors.push_back(row);
endtask

task automatic buildVectors();
    // Bubble must do nothing
    addRow(markIdle(aluInstr(0, fnAdds, 3, 1, 2, 0)), noReads, 0, 32'hFFFFFFFF, 32'd1,
           noWb, noMem, 0, 4'b0000);
    // Plain ALU in register and immediate forms
    addRow(aluInstr(0, fnAdd, 3, 1, 2, 0), readsOf(3, 1, 2), 0, 32'd5, 32'd7,
           wbTo(3, 32'd12), noMem, 0, 4'b0000);
    addRow(aluInstr(1, fnAdd, 4, 1, 6, -3), readsOf(4, 1, 0), 0, 32'd10, 0,
           wbTo(4, 32'd7), noMem, 0, 4'b0000);
    addRow(aluInstr(0, fnSub, 5, 1, 2, 0), readsOf(5, 1, 2), 0, 32'd20, 32'd8,
           wbTo(5, 32'd12), noMem, 0, 4'b0000);
    addRow(aluInstr(1, fnSub, 6, 1, 0, 2), readsOf(6, 1, 0), 0, 32'd1, 0,
           wbTo(6, 32'hFFFFFFFF), noMem, 0, 4'b0000);
    addRow(aluInstr(0, fnAnd, 7, 1, 2, 0), readsOf(7, 1, 2), 0, 32'hF0F0, 32'hFF00,
           wbTo(7, 32'hF000), noMem, 0, 4'b0000);
    addRow(aluInstr(1, fnAnd, 1, 2, 0, 16'hFF00), readsOf(1, 2, 0), 0, 32'h12345678, 0,
           wbTo(1, 32'h12345600), noMem, 0, 4'b0000);
    addRow(aluInstr(0, fnOr, 2, 1, 3, 0), readsOf(2, 1, 3), 0, 32'h0F00, 32'h00F0,
           wbTo(2, 32'h0FF0), noMem, 0, 4'b0000);
    addRow(aluInstr(1, fnOr, 8, 1, 0, 16'h8000), readsOf(8, 1, 0), 0, 0, 0,
           wbTo(8, 32'hFFFF8000), noMem, 0, 4'b0000);
    addRow(aluInstr(0, fnXor, 9, 1, 2, 0), readsOf(9, 1, 2), 0, 32'hAAAA5555, 32'hFFFF0000,
           wbTo(9, 32'h55555555), noMem, 0, 4'b0000);
    addRow(aluInstr(1, fnXor, 10, 1, 0, 3), readsOf(10, 1, 0), 0, 32'd1, 0,
           wbTo(10, 32'd2), noMem, 0, 4'b0000);
    addRow(aluInstr(0, fnNot, 11, 1, 5, 0), readsOf(11, 1, 0), 0, 32'h0000FFFF, 0,
           wbTo(11, 32'hFFFF0000), noMem, 0, 4'b0000);
    // Move group
    addRow(moveInstr(mvMov, 12, 3, 16'hFFFE), readsOf(12, 0, 0), 0, 0, 0,
           wbTo(12, 32'hFFFFFFFE), noMem, 0, 4'b0000);
    addRow(moveInstr(mvMovt, 12, 0, 16'h1234), readsOf(12, 0, 0), 32'hABCD5678, 0, 0,
           wbTo(12, 32'h12345678), noMem, 0, 4'b0000);
    addRow(moveInstr(mvClr, 13, 0, 0), readsOf(13, 0, 0), 32'h55, 0, 0,
           wbTo(13, 32'h0), noMem, 0, 4'b0000);
    addRow(moveInstr(mvSet, 14, 0, 0), readsOf(14, 0, 0), 0, 0, 0,
           wbTo(14, 32'hFFFFFFFF), noMem, 0, 4'b0000);
    addRow(moveInstr(mvLsl, 15, 2, 4), readsOf(15, 2, 0), 0, 32'd3, 0,
           wbTo(15, 32'h30), noMem, 0, 4'b0000);
    addRow(moveInstr(mvLsr, 1, 2, 31), readsOf(1, 2, 0), 0, 32'h80000000, 0,
           wbTo(1, 32'd1), noMem, 0, 4'b0000);
    // Flag setting with carry out and then signed overflow
    addRow(aluInstr(0, fnAdds, 2, 1, 3, 0), readsOf(2, 1, 3), 0, 32'hFFFFFFFF, 32'd1,
           wbTo(2, 0), noMem, 0, 4'b0110);
    addRow(aluInstr(0, fnAdds, 3, 1, 2, 0), readsOf(3, 1, 2), 0, 32'h7FFFFFFF, 32'd1,
           wbTo(3, 32'h80000000), noMem, 0, 4'b1001);
    addRow(aluInstr(0, fnAnds, 4, 1, 2, 0), readsOf(4, 1, 2), 0, 32'hF0000000, 32'h0F000000,
           wbTo(4, 0), noMem, 0, 4'b0101);
    addRow(aluInstr(0, fnAdd, 5, 1, 2, 0), readsOf(5, 1, 2), 0, 32'hFFFFFFFF, 32'd1,
           wbTo(5, 0), noMem, 0, 4'b0101);
    addRow(aluInstr(0, fnOrs, 6, 1, 2, 0), readsOf(6, 1, 2), 0, 32'h80000000, 0,
           wbTo(6, 32'h80000000), noMem, 0, 4'b1001);
    addRow(aluInstr(0, fnXors, 7, 1, 2, 0), readsOf(7, 1, 2), 0, 32'd5, 32'd5,
           wbTo(7, 0), noMem, 0, 4'b0101);
    addRow(aluInstr(0, fnSubs, 8, 1, 2, 0), readsOf(8, 1, 2), 0, 32'd5, 32'd3,
           wbTo(8, 32'd2), noMem, 0, 4'b0010);
    addRow(aluInstr(0, fnSubs, 9, 1, 2, 0), readsOf(9, 1, 2), 0, 32'd3, 32'd5,
           wbTo(9, 32'hFFFFFFFE), noMem, 0, 4'b1000);
    addRow(aluInstr(1, fnSubs, 10, 1, 0, 1), readsOf(10, 1, 0), 0, 32'h80000000, 0,
           wbTo(10, 32'h7FFFFFFF), noMem, 0, 4'b0011);
    // Branches against N0 Z0 C1 V1
    addRow(branchInstr(condEq), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condNe), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condHs), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condLo), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condMi), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condPl), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condVs), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condVc), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condHi), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condLs), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condGe), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condLt), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    addRow(branchInstr(condGt), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0011);
    addRow(branchInstr(condLe), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0011);
    // Equal compare gives N0 Z1 C1 V0
    addRow(aluInstr(0, fnSubs, 11, 1, 2, 0), readsOf(11, 1, 2), 0, 32'd5, 32'd5,
           wbTo(11, 0), noMem, 0, 4'b0110);
    addRow(branchInstr(condEq), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0110);
    addRow(branchInstr(condHi), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0110);
    addRow(branchInstr(condLs), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0110);
    addRow(branchInstr(condGe), noReads, 0, 0, 0, noWb, noMem, 1, 4'b0110);
    addRow(branchInstr(condGt), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0110);
    addRow(markIdle(branchInstr(condEq)), noReads, 0, 0, 0, noWb, noMem, 0, 4'b0110);
    // Store then load with load data supplied by the bench
    addRow(memInstr(1, 2, 1, -4), readsOf(2, 1, 0), 32'hDEADBEEF, 32'h1000, 0,
           noWb, memOf(0, 1, 32'h0FFC, 32'hDEADBEEF), 0, 4'b0110);
    addRow(memInstr(0, 5, 1, 16'h0010), readsOf(5, 1, 0), 0, 32'h2000, 0,
           wbTo(5, 0), memOf(1, 0, 32'h2010, 0), 0, 4'b0110);
endtask

`endif

// ==== bench/executeStageTb.sv ====
module executeStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;
    import datapathPkg::*;

    `include "executeVectors.svh"

    logic       clk;
    logic       rst;
    instr_t     instr;
    regData_t   regData;
    word_t      memRdData;
    regRead_t   regRead;
    writeBack_t writeBack;
    memReq_t    memReq;
    logic       branchTaken;
    flags_t     flags;

    int   errors;
    int   seed;
    logic vectorsReady;

    executeStage dut_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .regData     (regData),
        .memRdData   (memRdData),
        .regRead     (regRead),
        .writeBack   (writeBack),
        .memReq      (memReq),
        .branchTaken (branchTaken),
        .flags       (flags)
    );

    always #20 clk = ~clk;   // 40 ns period

    task automatic checkRegRead(string name, regRead_t exp, regRead_t act);
        if (exp !== act) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkFlags(string name, flags_t exp, flags_t act);
        if (exp !== act) begin
            errors++;
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkWriteBack(string name, writeBack_t exp, writeBack_t act);
        logic bad;
        bad = (exp.we !== act.we);
        if (exp.we)   // Address and data only count for a write
            bad = bad || (exp.addr !== act.addr) || (exp.data !== act.data);
        if (bad) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkMemReq(string name, memReq_t exp, memReq_t act);
        if (exp !== act) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    initial begin
        writeBack_t expWb;
        clk          = 1'b0;
        rst          = 1'b1;
        instr        = '0;
        regData      = '0;
        memRdData    = '0;
        errors       = 0;
        seed         = 34346;
        vectorsReady = 1'b0;
        buildVectors();
        vectorsReady = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1 checkFlags("flags", '0, flags);
        foreach (vectors[k]) begin
            @(negedge clk);
            instr     = vectors[k].instr;
            regData   = vectors[k].regData;
            memRdData = $random(seed);
            #19;   // Just before the rising edge
            expWb = vectors[k].expWb;
            if (vectors[k].expMem.read)
                expWb.data = memRdData;   // Load returns the memory word
            checkRegRead("regRead", vectors[k].expRd, regRead);
            checkWriteBack("writeBack", expWb, writeBack);
            checkMemReq("memReq", vectors[k].expMem, memReq);
            checkBit("branchTaken", vectors[k].expTaken, branchTaken);
            @(posedge clk);
            #1 checkFlags("flags", vectors[k].expFlags, flags);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from reset length plus the table
    initial begin
        wait (vectorsReady);
        #((10 + vectors.size() + 5) * 40);
        $display("Timeout: the run did not finish in the expected time");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== design/executeStage.sv ====
module executeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  isaPkg::instr_t         instr,
    input  datapathPkg::regData_t  regData,
    input  datapathPkg::word_t     memRdData,
    output datapathPkg::regRead_t  regRead,
    output datapathPkg::writeBack_t writeBack,
    output datapathPkg::memReq_t   memReq,
    output logic                   branchTaken,
    output datapathPkg::flags_t    flags
);
    import isaPkg::*;
    import datapathPkg::*;

    execOp_t op;
    logic    wbEnable;
    flags_t  flagMask;
    flags_t  candFlags;
    word_t   aluResult;
    word_t   loadData;

    instrDecoder decoder_i (
        .instr    (instr),
        .op       (op),
        .regRead  (regRead),
        .wbEnable (wbEnable),
        .flagMask (flagMask)
    );

    aluUnit alu_i (
        .op        (op),
        .imm       (instr.imm),
        .regData   (regData),
        .result    (aluResult),
        .candFlags (candFlags)
    );

    memAccessUnit mem_i (
        .op        (op),
        .imm       (instr.imm),
        .regData   (regData),
        .memRdData (memRdData),
        .memReq    (memReq),
        .loadData  (loadData)
    );

    flagRegister flagReg_i (
        .clk       (clk),
        .rst       (rst),
        .candFlags (candFlags),
        .flagMask  (flagMask),
        .flags     (flags)
    );

    branchCondition branch_i (
        .instr (instr),
        .flags (flags),
        .taken (branchTaken)
    );

    // Loads return memory data, everything else the ALU result
    assign writeBack.we   = wbEnable;
    assign writeBack.addr = regRead.dest;
    assign writeBack.data = (op == opLoad) ? loadData : aluResult;

endmodule

// ==== design/branchCondition.sv ====
module branchCondition (
    input  isaPkg::instr_t      instr,
    input  datapathPkg::flags_t flags,
    output logic                taken
);
    import isaPkg::*;

    logic condMet;

    always_comb begin
        case (instr.cond)
            condEq:  condMet = flags.z;
            condNe:  condMet = !flags.z;
            condHs:  condMet = flags.c;
            condLo:  condMet = !flags.c;
            condMi:  condMet = flags.n;
            condPl:  condMet = !flags.n;
            condVs:  condMet = flags.v;
            condVc:  condMet = !flags.v;
            condHi:  condMet = flags.c && !flags.z;      // Unsigned higher
            condLs:  condMet = !(flags.c && !flags.z);
            condGe:  condMet = (flags.n == flags.v);      // Signed compares
            condLt:  condMet = (flags.n != flags.v);
            condGt:  condMet = !flags.z && (flags.n == flags.v);
            condLe:  condMet = !(!flags.z && (flags.n == flags.v));
            default: condMet = 1'b0;
        endcase
    end

    // Only a valid branch can redirect
    assign taken = instr.valid && (instr.opClass == branchOp) && condMet;

endmodule

// ==== design/flagRegister.sv ====
module flagRegister (
    input  logic                clk,
    input  logic                rst,
    input  datapathPkg::flags_t candFlags,
    input  datapathPkg::flags_t flagMask,
    output datapathPkg::flags_t flags
);
    import datapathPkg::*;

    flags_t flagsNext;

    // Take masked flags from the ALU, keep the rest
    assign flagsNext = flags_t'((flags & ~flagMask) | (candFlags & flagMask));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= flagsNext;
        end
    end

    holdWithoutMask: assert property (
        @(posedge clk) disable iff (rst)
        flagMask == '0 |=> $stable(flags)
    ) else $error("flagRegister: NZCV changed with an empty mask");

endmodule

// ==== design/memAccessUnit.sv ====
module memAccessUnit (
    input  isaPkg::execOp_t       op,
    input  isaPkg::imm_t          imm,
    input  datapathPkg::regData_t regData,
    input  datapathPkg::word_t    memRdData,
    output datapathPkg::memReq_t  memReq,
    output datapathPkg::word_t    loadData
);
    import isaPkg::*;

    always_comb begin
        memReq = '0;
        if (op inside {opLoad, opStore})
            memReq.addr = regData.first + extendImm(imm);   // Base plus offset
        if (op == opStore) begin
            memReq.write = 1'b1;
            memReq.data  = regData.dest;
        end
        memReq.read = (op == opLoad);
    end

    assign loadData = (op == opLoad) ? memRdData : '0;

    oneAccessPerCycle: assert final (!(memReq.read && memReq.write))
        else $error("memAccessUnit: read and write requested together");

endmodule

// ==== design/aluUnit.sv ====
module aluUnit (
    input  isaPkg::execOp_t       op,
    input  isaPkg::imm_t          imm,
    input  datapathPkg::regData_t regData,
    output datapathPkg::word_t    result,
    output datapathPkg::flags_t   candFlags
);
    import isaPkg::*;
    import datapathPkg::*;

    logic        isImmForm;
    logic        isSub;
    logic        isArith;
    word_t       opA;
    word_t       opB;
    word_t       addB;        // opB, inverted for subtract
    logic [32:0] sum;

    assign isImmForm = op inside {opAddI, opSubI, opAndI, opOrI, opXorI};
    assign isSub     = op inside {opSubR, opSubI};
    assign isArith   = op inside {opAddR, opAddI, opSubR, opSubI};

    assign opA  = regData.first;
    assign opB  = isImmForm ? extendImm(imm) : regData.second;
    assign addB = isSub ? ~opB : opB;

    // One adder for both, carry out is not-borrow on subtract
    assign sum = {1'b0, opA} + {1'b0, addB} + {32'd0, isSub};

    always_comb begin
        case (op)
            opAddR, opAddI,
            opSubR, opSubI:  result = sum[31:0];
            opAndR, opAndI:  result = opA & opB;
            opOrR,  opOrI:   result = opA | opB;
            opXorR, opXorI:  result = opA ^ opB;
            opNot:           result = ~opA;
            opMov:           result = extendImm(imm);
            opMovt:          result = {imm, regData.dest[15:0]};
            opClr:           result = '0;
            opSet:           result = '1;
            opLsl:           result = opA << imm;   // Amount taken from immediate
            opLsr:           result = opA >> imm;
            default:         result = '0;
        endcase
    end

    always_comb begin
        candFlags.n = result[31];
        candFlags.z = (result == '0);
        candFlags.c = isArith & sum[32];
        // Signs of adder inputs agree but result sign flips
        candFlags.v = isArith & (opA[31] == addB[31]) & (result[31] != opA[31]);
    end

endmodule

// ==== design/instrDecoder.sv ====
module instrDecoder (
    input  isaPkg::instr_t        instr,
    output isaPkg::execOp_t       op,
    output datapathPkg::regRead_t regRead,
    output logic                  wbEnable,
    output datapathPkg::flags_t   flagMask
);
    import isaPkg::*;
    import datapathPkg::*;

    localparam flags_t allFlags = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b1};
    localparam flags_t nzFlags  = '{n: 1'b1, z: 1'b1, c: 1'b0, v: 1'b0};

    logic isImm;

    assign isImm = (instr.opClass == immOp);

    always_comb begin
        op       = opNone;
        regRead  = '0;
        flagMask = '0;
        if (instr.valid) begin
            case (instr.opClass)
                immOp, regOp: begin
                    regRead.dest = instr.dest;
                    if (isImm && !instr.special) begin
                        case (instr.moveFunc)
                            mvMov:  op = opMov;
                            mvMovt: op = opMovt;   // Keeps low half of old dest
                            mvClr:  op = opClr;
                            mvSet:  op = opSet;
                            mvLsl:  op = opLsl;
                            mvLsr:  op = opLsr;
                            default: op = opNone;
                        endcase
                        if (op inside {opLsl, opLsr})
                            regRead.first = instr.src1;
                    end else begin
                        regRead.first = instr.src1;
                        if (!isImm && instr.aluFunc != fnNot)
                            regRead.second = instr.src2;
                        case (instr.aluFunc)
                            fnAdd, fnAdds: op = isImm ? opAddI : opAddR;
                            fnSub, fnSubs: op = isImm ? opSubI : opSubR;
                            fnAnd, fnAnds: op = isImm ? opAndI : opAndR;
                            fnOr,  fnOrs:  op = isImm ? opOrI  : opOrR;
                            fnXor, fnXors: op = isImm ? opXorI : opXorR;
                            fnNot:         op = opNot;
                            default:       op = opNone;
                        endcase
                        case (instr.aluFunc)
                            fnAdds, fnSubs:         flagMask = allFlags;
                            fnAnds, fnOrs, fnXors:  flagMask = nzFlags;   // C and V untouched
                            default:                flagMask = '0;
                        endcase
                    end
                end
                memOp: begin
                    regRead.dest  = instr.dest;   // Store data
                    regRead.first = instr.src1;   // Base
                    op = instr.moveFunc[0] ? opStore : opLoad;
                end
                default: op = opNone;   // Branches only look at flags
            endcase
            if (op == opNone)
                regRead = '0;
        end
    end

    assign wbEnable = !(op inside {opNone, opStore});

    // A bubble must never write a register or touch the flags
    noSideEffectWhenIdle: assert final (instr.valid || (!wbEnable && flagMask == '0))
        else $error("decoder: write enable or flag mask without valid instruction");

endmodule

// ==== design/isaPkg.sv ====
package isaPkg;

    // First-level decode
    typedef enum logic [1:0] {
        immOp    = 2'b00,
        regOp    = 2'b01,
        memOp    = 2'b10,
        branchOp = 2'b11
    } instrClass_t;

    // Second-level decode, bit 3 selects the flag-setting form
    typedef enum logic [3:0] {
        fnAdd  = 4'b0001,
        fnSub  = 4'b0010,
        fnAnd  = 4'b0011,
        fnOr   = 4'b0100,
        fnXor  = 4'b0101,
        fnNot  = 4'b0110,
        fnAdds = 4'b1001,
        fnSubs = 4'b1010,
        fnAnds = 4'b1011,
        fnOrs  = 4'b1100,
        fnXors = 4'b1101
    } aluFunc_t;

    typedef enum logic [2:0] {
        mvMov  = 3'b000,
        mvMovt = 3'b001,
        mvClr  = 3'b010,
        mvSet  = 3'b011,
        mvLsl  = 3'b100,
        mvLsr  = 3'b101
    } moveFunc_t;

    typedef enum logic [3:0] {
        condEq, condNe, condHs, condLo, condMi, condPl, condVs,
        condVc, condHi, condLs, condGe, condLt, condGt, condLe
    } branchCond_t;

    typedef logic signed [15:0] imm_t;

    typedef struct packed {
        logic                  valid;
        instrClass_t           opClass;
        logic                  special;   // Set for ALU ops in the immediate class
        aluFunc_t              aluFunc;
        moveFunc_t             moveFunc;  // Bit 0 also picks store over load
        branchCond_t           cond;
        imm_t                  imm;
        datapathPkg::regIdx_t  dest;
        datapathPkg::regIdx_t  src1;
        datapathPkg::regIdx_t  src2;
    } instr_t;

    // Internal operation handed from decoder to ALU and memory unit
    typedef enum logic [4:0] {
        opNone,
        opAddR, opAddI, opSubR, opSubI,
        opAndR, opAndI, opOrR, opOrI, opXorR, opXorI,
        opNot,
        opMov, opMovt, opClr, opSet, opLsl, opLsr,
        opLoad, opStore
    } execOp_t;

    function automatic datapathPkg::word_t extendImm(imm_t value);
        return {{16{value[15]}}, value};
    endfunction

endpackage

// ==== design/datapathPkg.sv ====
package datapathPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;   // r0 .. r15

    // Condition flags, also used as a per-flag enable mask
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // Register file read addresses
    typedef struct packed {
        regIdx_t dest;
        regIdx_t first;
        regIdx_t second;
    } regRead_t;

    typedef struct packed {
        word_t dest;     // Old dest value or store data
        word_t first;
        word_t second;
    } regData_t;

    typedef struct packed {
        logic    we;
        regIdx_t addr;
        word_t   data;
    } writeBack_t;

    // Single-cycle data memory port
    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t data;
    } memReq_t;

endpackage
